//--- compile.f
common/mc_apb_pkg.sv
rtl/apb_reg_decode.sv
rank_ctrl/rank_mr_regs.sv
rtl/training_ctrl.sv
rtl/intr_ctrl.sv
rtl/mr4_pulse_timer.sv
rtl/mc_apb_regs_top.sv
tests/tb_mc_apb_regs.sv

//--- run.sh
#!/usr/bin/env bash
# build the APB register testbench with Verilator, run it, scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mc_apb_regs -f compile.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run.sh: testbench reported failure"
  exit 1
fi
echo "run.sh: done"

//--- tests/tb_mc_apb_regs.sv
//////////////////////////////
// random-stimulus testbench of the APB register slave
// checks each register rule against a model kept here
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mc_apb_regs;

  import mc_apb_pkg::*;

  localparam int EST_CYCLES = 2500;                  // length of all six tests rounded up
  localparam int MAX_CYCLES = 8 * EST_CYCLES;
  localparam int TICKS      = 10;                    // cycles per MR4 interval unit
  localparam logic [15:0] A_RANK  = 16'h0000;
  localparam logic [15:0] A_TRAIN = 16'h0010;
  localparam logic [15:0] A_MRCTL = 16'h0018;
  localparam logic [15:0] A_MR4   = 16'h0040;
  localparam logic [15:0] A_ISTAT = 16'h0060;
  localparam logic [15:0] A_IEN   = 16'h0064;

  logic               pclk = 1'b0;
  logic               prst_n;
  logic [15:0]        paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [31:0]        pwdata;
  logic [3:0]         pstrb;
  logic               pready;
  logic [31:0]        prdata;
  logic               pslverr;
  logic [NB_RANK-1:0] rank_mrw;
  logic [NB_RANK-1:0] rank_mrr;
  logic [NB_RANK-1:0] mrw_done;
  logic [NB_RANK-1:0] mrr_done;
  logic [TRAIN_W-1:0] train_start;
  logic [TRAIN_W-1:0] train_done;
  logic [ERR_W-1:0]   mc_err;
  logic               mc_intr;
  logic               mr4_pulse;

  //////////////////////////////
  // reference model state
  //////////////////////////////
  logic [2:0]         m_idx;
  logic [7:0]         m_addr [NB_RANK];
  logic [7:0]         m_data [NB_RANK];
  logic [NB_RANK-1:0] m_busy;
  logic [NB_RANK-1:0] m_mrw_done;
  logic [NB_RANK-1:0] m_mrr_done;
  logic [TRAIN_W-1:0] m_train_busy;
  logic [NB_RANK-1:0] m_rank_stat;
  logic [ERR_W-1:0]   m_err_stat;
  logic [NB_RANK-1:0] m_rank_en;
  logic [ERR_W-1:0]   m_err_en;
  logic [5:0]         m_interval;
  logic               m_dis;

  logic [31:0] lfsr;
  int          cycles = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;
  int          test_err_base = 0;

  mc_apb_regs_top uut (
    .pclk_i(pclk), .prst_ni(prst_n), .paddr_i(paddr), .psel_i(psel),
    .penable_i(penable), .pwrite_i(pwrite), .pwdata_i(pwdata), .pstrb_i(pstrb),
    .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
    .rank_mrw_o(rank_mrw), .rank_mrr_o(rank_mrr), .mrw_done_i(mrw_done),
    .mrr_done_i(mrr_done), .train_start_o(train_start), .train_done_i(train_done),
    .mc_err_i(mc_err), .mc_intr_o(mc_intr), .mr4_pulse_o(mr4_pulse)
  );

  always #5 pclk = ~pclk;

  always @(posedge pclk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic is_mapped(input logic [15:0] a);
    return a == A_RANK || a == A_TRAIN || a == A_MRCTL || a == A_MR4 ||
           a == A_ISTAT || a == A_IEN;
  endfunction

  function automatic logic [31:0] model_read(input logic [15:0] a);
    logic [31:0] d;
    d = '0;
    case (a)
      A_RANK:
      begin
        d[26:24] = m_idx;
        if (m_idx < NB_RANK)
        begin
          d[7:0]  = m_addr[m_idx];
          d[15:8] = m_data[m_idx];
          d[18]   = m_busy[m_idx];                   // busy
          d[21]   = m_mrw_done[m_idx];
          d[22]   = m_mrr_done[m_idx];
        end
      end
      A_TRAIN: d[TRAIN_W-1:0] = m_train_busy;
      A_MRCTL: d[11] = m_dis;
      A_MR4:   d[5:0] = m_interval;
      A_ISTAT:
      begin
        d[NB_RANK-1:0] = m_rank_stat;
        d[14:8]        = m_err_stat;
      end
      A_IEN:
      begin
        d[NB_RANK-1:0] = m_rank_en;
        d[14:8]        = m_err_en;
      end
      default: d = '0;
    endcase
    return d;
  endfunction

  function automatic logic model_intr();
    return (|(m_rank_stat & m_rank_en)) | (|(m_err_stat & m_err_en));
  endfunction

  task automatic next_cycle();
    @(posedge pclk);
    #1;                                              // drive after the edge
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    assert (got === exp)
    else
    begin
      $display("ERROR at time %0t: %s got %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base)
      $display("test %0d %s: ok", test_cnt, name);
    else
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  //////////////////////////////
  // APB transfers
  //////////////////////////////
  task automatic apb_xfer(input logic [15:0] a, input logic wr, input logic [31:0] d,
                          input logic [3:0] s, output logic [31:0] rd, output logic err);
    paddr   = a;
    pwrite  = wr;
    pwdata  = d;
    pstrb   = s;
    psel    = 1'b1;
    penable = 1'b0;
    next_cycle();
    penable = 1'b1;
    #4;                                              // mid access phase
    rd  = prdata;
    err = pslverr;
    check_eq(32'(pready), 32'd1, "pready in access phase");
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic model_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
    case (a)
      A_RANK:
      begin
        if (m_idx < NB_RANK)
        begin
          if (s[0])
            m_addr[m_idx] = d[7:0];
          if (s[1])
            m_data[m_idx] = d[15:8];
          if (s[2] & (d[16] | d[17]))
            m_busy[m_idx] = 1'b1;                    // MRW or MRR issued
        end
        if (s[3])
          m_idx = d[26:24];                          // takes effect for the next access
      end
      A_TRAIN: if (s[0]) m_train_busy = m_train_busy | d[TRAIN_W-1:0];
      A_MRCTL: if (s[1]) m_dis = d[11];
      A_MR4:   if (s[0]) m_interval = d[5:0];
      A_IEN:
      begin
        if (s[0])
          m_rank_en = d[NB_RANK-1:0];
        if (s[1])
          m_err_en = d[14:8];
      end
      default: ;
    endcase
  endtask

  task automatic reg_write(input logic [15:0] a, input logic [31:0] d, input logic [3:0] s);
    logic [31:0] rd;
    logic        err;
    apb_xfer(a, 1'b1, d, s, rd, err);
    check_eq(32'(err), 32'd0, "pslverr on mapped write");
    model_write(a, d, s);
  endtask

  task automatic read_check(input logic [15:0] a, input string what);
    logic [31:0] exp;
    logic [31:0] rd;
    logic        err;
    exp = model_read(a);
    apb_xfer(a, 1'b0, 32'd0, 4'd0, rd, err);
    check_eq(rd, exp, what);
    check_eq(32'(err), 32'd0, {what, " pslverr"});
    if (a == A_RANK && m_idx < NB_RANK)
    begin
      m_mrw_done[m_idx] = 1'b0;                      // clear on read
      m_mrr_done[m_idx] = 1'b0;
    end
    if (a == A_ISTAT)
    begin
      m_rank_stat = '0;
      m_err_stat  = '0;
    end
  endtask

  // one-cycle done and error pulses from the controller side
  task automatic pulse_events(input logic [NB_RANK-1:0] w, input logic [NB_RANK-1:0] r,
                              input logic [ERR_W-1:0] e);
    mrw_done = w;
    mrr_done = r;
    mc_err   = e;
    next_cycle();
    mrw_done = '0;
    mrr_done = '0;
    mc_err   = '0;
    m_busy      = m_busy & ~(w | r);
    m_mrw_done  = m_mrw_done | w;
    m_mrr_done  = m_mrr_done | r;
    m_rank_stat = m_rank_stat | w | r;
    m_err_stat  = m_err_stat | e;
  endtask

  initial
  begin
    logic [31:0]        rnd;
    logic [31:0]        rnd2;
    logic [31:0]        d;
    logic [31:0]        rd;
    logic [15:0]        a;
    logic               err;
    logic [2:0]         rk;
    logic               is_mrr;
    logic [NB_RANK-1:0] exp_strb;
    int                 ivl;
    int                 period;
    logic               seen;

    lfsr     = 32'hdc02_78ee;
    prst_n   = 1'b0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    pstrb    = '0;
    mrw_done = '0;
    mrr_done = '0;
    train_done = '0;
    mc_err   = '0;
    m_idx    = '0;
    for (int r = 0; r < NB_RANK; r++)
    begin
      m_addr[r] = '0;
      m_data[r] = '0;
    end
    m_busy       = '0;
    m_mrw_done   = '0;
    m_mrr_done   = '0;
    m_train_busy = '0;
    m_rank_stat  = '0;
    m_err_stat   = '0;
    m_rank_en    = '1;
    m_err_en     = '1;
    m_interval   = 6'd2;
    m_dis        = 1'b0;
    repeat (5) @(posedge pclk);
    #1 prst_n = 1'b1;

    // reset values
    check_eq(32'({rank_mrw, rank_mrr, train_start, mc_intr, mr4_pulse}), 32'd0,
             "strobes after reset");
    check_eq(32'(pready), 32'd0, "pready while idle");
    read_check(A_RANK, "rank word reset");
    read_check(A_TRAIN, "training word reset");
    read_check(A_MRCTL, "mr control reset");
    read_check(A_MR4, "mr4 interval reset");
    read_check(A_ISTAT, "interrupt status reset");
    read_check(A_IEN, "interrupt enable reset");
    end_test("reset values");

    // lanes of the indexed rank
    for (int i = 0; i < 40; i++)
    begin
      d = rand_bits(32);
      d[17:16] = 2'b00;                              // no commands here
      if (i % 5 != 0)
        d[26:25] = 2'b00;                            // mostly valid ranks
      rnd = rand_bits(4);
      reg_write(A_RANK, d, rnd[3:0]);
      read_check(A_RANK, "rank word lanes");
    end
    reg_write(A_RANK, 32'h0600_0000, 4'b1000);
    read_check(A_RANK, "rank index out of range");
    for (int i = 0; i < 8; i++)
    begin
      rnd = rand_bits(14);
      a = {rnd[13:0], 2'b00};
      if (is_mapped(a))
        a = 16'h0008;
      apb_xfer(a, 1'b0, 32'd0, 4'd0, rd, err);
      check_eq(32'(err), 32'd1, "pslverr on unmapped read");
      check_eq(rd, 32'd0, "unmapped read data");
      apb_xfer(a, 1'b1, rand_bits(32), 4'hf, rd, err);
      check_eq(32'(err), 32'd1, "pslverr on unmapped write");
    end
    end_test("mode register lanes");

    // MRW and MRR commands
    for (int i = 0; i < 12; i++)
    begin
      rnd    = rand_bits(2);
      rk     = {2'b00, rnd[0]};
      is_mrr = rnd[1];
      reg_write(A_RANK, {5'd0, rk, 24'd0}, 4'b1000);
      reg_write(A_RANK, is_mrr ? 32'h0002_0000 : 32'h0001_0000, 4'b0100);
      exp_strb = NB_RANK'(1) << rk;
      check_eq(32'(is_mrr ? rank_mrr : rank_mrw), 32'(exp_strb), "command strobe");
      check_eq(32'(is_mrr ? rank_mrw : rank_mrr), 32'd0, "other command strobe");
      next_cycle();
      check_eq(32'({rank_mrw, rank_mrr}), 32'd0, "strobe after one cycle");
      read_check(A_RANK, "busy after command");
      rnd = rand_bits(4);
      repeat (rnd[1:0]) read_check(A_RANK, "busy while waiting");
      repeat (rnd[3:2]) next_cycle();
      pulse_events(is_mrr ? '0 : exp_strb, is_mrr ? exp_strb : '0, '0);
      read_check(A_RANK, "done after completion");
      read_check(A_RANK, "done cleared by read");
    end
    end_test("rank commands");

    // training starts
    for (int i = 0; i < 20; i++)
    begin
      rnd = rand_bits(TRAIN_W);
      reg_write(A_TRAIN, rnd, 4'b0001);
      check_eq(32'(train_start), rnd, "training start pulse");
      next_cycle();
      check_eq(32'(train_start), 32'd0, "training start after one cycle");
      read_check(A_TRAIN, "training busy");
      rnd = rand_bits(TRAIN_W);
      train_done = rnd[TRAIN_W-1:0];
      next_cycle();
      train_done = '0;
      m_train_busy = m_train_busy & ~rnd[TRAIN_W-1:0];
      read_check(A_TRAIN, "training busy after done");
    end
    end_test("training");

    // interrupt status and enables
    read_check(A_ISTAT, "status before interrupt test");
    for (int i = 0; i < 30; i++)
    begin
      rnd = rand_bits(16);
      reg_write(A_IEN, rnd, 4'b0011);
      rnd  = rand_bits(11);
      rnd2 = rand_bits(11);
      rnd  = rnd & rnd2;                             // sparse events
      pulse_events(rnd[1:0], rnd[3:2], rnd[10:4]);
      check_eq(32'(mc_intr), 32'(model_intr()), "interrupt pin");
      if (i % 3 == 2)
      begin
        read_check(A_IEN, "interrupt enables");
        read_check(A_ISTAT, "interrupt status read");
        check_eq(32'(mc_intr), 32'(model_intr()), "interrupt pin after clear");
      end
    end
    end_test("interrupts");

    // MR4 pulse period
    reg_write(A_MRCTL, 32'd0, 4'b0010);
    for (int i = 0; i < 4; i++)
    begin
      rnd    = rand_bits(3);
      ivl    = int'(rnd[2:0]) + 1;
      period = ivl * TICKS;
      reg_write(A_MR4, 32'(ivl), 4'b0001);
      for (int n = 0; n <= 2 * period + 2; n++)
      begin
        check_eq(32'(mr4_pulse), 32'(n > 0 && n % period == 0), "mr4 pulse timing");
        next_cycle();
      end
    end
    read_check(A_MR4, "mr4 interval readback");
    reg_write(A_MRCTL, 32'h0000_0800, 4'b0010);      // disable
    seen = 1'b0;
    repeat (200)
    begin
      seen = seen | mr4_pulse;
      next_cycle();
    end
    check_eq(32'(seen), 32'd0, "mr4 pulse while disabled");
    read_check(A_MRCTL, "mr4 disable readback");
    reg_write(A_MRCTL, 32'd0, 4'b0010);
    reg_write(A_MR4, 32'd0, 4'b0001);
    seen = 1'b0;
    repeat (200)
    begin
      seen = seen | mr4_pulse;
      next_cycle();
    end
    check_eq(32'(seen), 32'd0, "mr4 pulse with zero interval");
    end_test("mr4 timer");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/mc_apb_regs_top.sv
//////////////////////////////
// APB register slave of the LPDDR3/4 controller
// decoder and register blocks on one 32-bit port
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mc_apb_regs_top (
  input  wire                                pclk_i,
  input  wire                                prst_ni,
  input  wire  [mc_apb_pkg::APB_ADDR_W-1:0]  paddr_i,
  input  wire                                psel_i,
  input  wire                                penable_i,
  input  wire                                pwrite_i,
  input  wire  [mc_apb_pkg::APB_DATA_W-1:0]  pwdata_i,
  input  wire  [3:0]                         pstrb_i,
  output logic                               pready_o,
  output logic [mc_apb_pkg::APB_DATA_W-1:0]  prdata_o,
  output logic                               pslverr_o,
  output logic [mc_apb_pkg::NB_RANK-1:0]     rank_mrw_o,
  output logic [mc_apb_pkg::NB_RANK-1:0]     rank_mrr_o,
  input  wire  [mc_apb_pkg::NB_RANK-1:0]     mrw_done_i,
  input  wire  [mc_apb_pkg::NB_RANK-1:0]     mrr_done_i,
  output logic [mc_apb_pkg::TRAIN_W-1:0]     train_start_o,
  input  wire  [mc_apb_pkg::TRAIN_W-1:0]     train_done_i,
  input  wire  [mc_apb_pkg::ERR_W-1:0]       mc_err_i,
  output logic                               mc_intr_o,
  output logic                               mr4_pulse_o
);

  import mc_apb_pkg::*;

  logic [NB_WORD-1:0]    wr_sel;
  logic [NB_WORD-1:0]    rd_sel;
  logic [3:0]            byte_we;
  logic [APB_DATA_W-1:0] rank_rdata;
  logic [APB_DATA_W-1:0] train_rdata;
  logic [APB_DATA_W-1:0] intr_rdata;
  logic [APB_DATA_W-1:0] mr4_rdata;

  apb_reg_decode u_decode (
    .paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
    .pstrb_i(pstrb_i), .wr_sel_o(wr_sel), .rd_sel_o(rd_sel), .byte_we_o(byte_we),
    .pready_o(pready_o), .pslverr_o(pslverr_o)
  );

  rank_mr_regs u_rank (
    .pclk_i(pclk_i), .prst_ni(prst_ni), .wr_sel_i(wr_sel[SEL_RANK]),
    .rd_sel_i(rd_sel[SEL_RANK]), .byte_we_i(byte_we), .wdata_i(pwdata_i),
    .mrw_done_i(mrw_done_i), .mrr_done_i(mrr_done_i), .rdata_o(rank_rdata),
    .rank_mrw_o(rank_mrw_o), .rank_mrr_o(rank_mrr_o)
  );

  training_ctrl u_train (
    .pclk_i(pclk_i), .prst_ni(prst_ni), .wr_sel_i(wr_sel[SEL_TRAIN]),
    .rd_sel_i(rd_sel[SEL_TRAIN]), .byte_we0_i(byte_we[0]),
    .wdata_i(pwdata_i[TRAIN_W-1:0]), .train_done_i(train_done_i),
    .rdata_o(train_rdata), .train_start_o(train_start_o)
  );

  intr_ctrl u_intr (
    .pclk_i(pclk_i), .prst_ni(prst_ni), .stat_rd_i(rd_sel[SEL_ISTAT]),
    .en_wr_sel_i(wr_sel[SEL_IEN]), .en_rd_sel_i(rd_sel[SEL_IEN]),
    .byte_we_i(byte_we[1:0]), .wdata_i(pwdata_i[15:0]), .mrw_done_i(mrw_done_i),
    .mrr_done_i(mrr_done_i), .mc_err_i(mc_err_i), .rdata_o(intr_rdata),
    .mc_intr_o(mc_intr_o)
  );

  mr4_pulse_timer u_mr4 (
    .pclk_i(pclk_i), .prst_ni(prst_ni), .mr4_wr_i(wr_sel[SEL_MR4]),
    .ctl_wr_i(wr_sel[SEL_MRCTL]), .rd_sel_i({rd_sel[SEL_MRCTL], rd_sel[SEL_MR4]}),
    .byte_we_i(byte_we[1:0]), .wdata_i(pwdata_i), .rdata_o(mr4_rdata),
    .mr4_pulse_o(mr4_pulse_o)
  );

  // blocks drive zero when not read
  assign prdata_o = rank_rdata | train_rdata | intr_rdata | mr4_rdata;

endmodule

`default_nettype wire

//--- rtl/mr4_pulse_timer.sv
//////////////////////////////
// MR4 read timer; a pulse every interval x 10 cycles,
// restarted by any write to its two words
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mr4_pulse_timer (
  input  wire                                pclk_i,
  input  wire                                prst_ni,
  input  wire                                mr4_wr_i,
  input  wire                                ctl_wr_i,
  input  wire  [1:0]                         rd_sel_i,    // 1 mrctl, 0 interval
  input  wire  [1:0]                         byte_we_i,
  input  wire  [mc_apb_pkg::APB_DATA_W-1:0]  wdata_i,
  output logic [mc_apb_pkg::APB_DATA_W-1:0]  rdata_o,
  output logic                               mr4_pulse_o
);

  import mc_apb_pkg::*;

  logic [MR4_INTERVAL_W-1:0] interval_q;
  logic                      dis_q;
  logic [MR4_CNT_W-1:0]      count_q;
  logic [MR4_CNT_W-1:0]      target;
  logic                      run;

  assign target      = MR4_CNT_W'(interval_q) * MR4_CNT_W'(MR4_TICKS_PER_UNIT);
  assign run         = ~dis_q & (|interval_q);     // zero interval stops the timer
  assign mr4_pulse_o = run & (count_q == target);

  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
    begin
      interval_q <= MR4_INTERVAL_RST;
      dis_q      <= 1'b0;
      count_q    <= '0;
    end
    else
    begin
      if (mr4_wr_i & byte_we_i[0])
      begin
        interval_q <= wdata_i[MR4_INTERVAL_W-1:0];
      end
      if (ctl_wr_i & byte_we_i[1])
      begin
        dis_q <= wdata_i[MR4_DIS_BIT];
      end
      if (mr4_wr_i | ctl_wr_i)
        count_q <= '0;                                // restart
      else if (mr4_pulse_o)
        count_q <= MR4_CNT_W'(1);
      else if (run)
        count_q <= count_q + 1'b1;
    end
  end

  always_comb
  begin
    rdata_o = '0;
    if (rd_sel_i[0])
      rdata_o[MR4_INTERVAL_W-1:0] = interval_q;
    if (rd_sel_i[1])
      rdata_o[MR4_DIS_BIT] = dis_q;
  end

endmodule

`default_nettype wire

//--- rtl/intr_ctrl.sv
//////////////////////////////
// sticky rank-done and error status, clear on read,
// with enables masking them onto the interrupt pin
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module intr_ctrl (
  input  wire                                pclk_i,
  input  wire                                prst_ni,
  input  wire                                stat_rd_i,
  input  wire                                en_wr_sel_i,
  input  wire                                en_rd_sel_i,
  input  wire  [1:0]                         byte_we_i,
  input  wire  [15:0]                        wdata_i,
  input  wire  [mc_apb_pkg::NB_RANK-1:0]     mrw_done_i,
  input  wire  [mc_apb_pkg::NB_RANK-1:0]     mrr_done_i,
  input  wire  [mc_apb_pkg::ERR_W-1:0]       mc_err_i,
  output logic [mc_apb_pkg::APB_DATA_W-1:0]  rdata_o,
  output logic                               mc_intr_o
);

  import mc_apb_pkg::*;

  logic [NB_RANK-1:0] rank_stat_q;
  logic [ERR_W-1:0]   err_stat_q;
  logic [NB_RANK-1:0] rank_en_q;
  logic [ERR_W-1:0]   err_en_q;
  logic [NB_RANK-1:0] rank_set;

  assign rank_set = mrw_done_i | mrr_done_i;

  //////////////////////////////
  // status and enables
  //////////////////////////////
  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
    begin
      rank_stat_q <= '0;
      err_stat_q  <= '0;
      rank_en_q   <= '1;
      err_en_q    <= '1;
    end
    else
    begin
      // a set in the read cycle survives the clear
      rank_stat_q <= rank_set | (stat_rd_i ? '0 : rank_stat_q);
      err_stat_q  <= mc_err_i | (stat_rd_i ? '0 : err_stat_q);
      if (en_wr_sel_i & byte_we_i[0])
      begin
        rank_en_q <= wdata_i[NB_RANK-1:0];
      end
      if (en_wr_sel_i & byte_we_i[1])
      begin
        err_en_q <= wdata_i[ERR_LSB +: ERR_W];
      end
    end
  end

  assign mc_intr_o = (|(rank_stat_q & rank_en_q)) | (|(err_stat_q & err_en_q));

  always_comb
  begin
    rdata_o = '0;
    if (stat_rd_i)
    begin
      rdata_o[NB_RANK-1:0]      = rank_stat_q;
      rdata_o[ERR_LSB +: ERR_W] = err_stat_q;
    end
    if (en_rd_sel_i)
    begin
      rdata_o[NB_RANK-1:0]      = rank_en_q;
      rdata_o[ERR_LSB +: ERR_W] = err_en_q;
    end
  end

endmodule

`default_nettype wire

//--- rtl/training_ctrl.sv
//////////////////////////////
// training start register; a one-cycle start pulse
// and a busy bit per training kind
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module training_ctrl (
  input  wire                                pclk_i,
  input  wire                                prst_ni,
  input  wire                                wr_sel_i,
  input  wire                                rd_sel_i,
  input  wire                                byte_we0_i,
  input  wire  [mc_apb_pkg::TRAIN_W-1:0]     wdata_i,
  input  wire  [mc_apb_pkg::TRAIN_W-1:0]     train_done_i,
  output logic [mc_apb_pkg::APB_DATA_W-1:0]  rdata_o,
  output logic [mc_apb_pkg::TRAIN_W-1:0]     train_start_o
);

  import mc_apb_pkg::*;

  logic [TRAIN_W-1:0] start_set;                    // bit k is train_kind_e k
  logic [TRAIN_W-1:0] busy_q;

  assign start_set = (wr_sel_i & byte_we0_i) ? wdata_i : '0;

  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
    begin
      train_start_o <= '0;
      busy_q        <= '0;
    end
    else
    begin
      train_start_o <= start_set;                     // pulse the cycle after the write
      busy_q        <= start_set | (busy_q & ~train_done_i);   // start beats done
    end
  end

  always_comb
  begin
    rdata_o = '0;
    if (rd_sel_i)
    begin
      rdata_o[TRAIN_W-1:0] = busy_q;
    end
  end

endmodule

`default_nettype wire

//--- rank_ctrl/rank_mr_regs.sv
//////////////////////////////
// per-rank mode register access with address/data,
// MRW/MRR strobes to the controller, busy and sticky done flags
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rank_mr_regs (
  input  wire                                pclk_i,
  input  wire                                prst_ni,
  input  wire                                wr_sel_i,
  input  wire                                rd_sel_i,
  input  wire  [3:0]                         byte_we_i,
  input  wire  [mc_apb_pkg::APB_DATA_W-1:0]  wdata_i,
  input  wire  [mc_apb_pkg::NB_RANK-1:0]     mrw_done_i,
  input  wire  [mc_apb_pkg::NB_RANK-1:0]     mrr_done_i,
  output logic [mc_apb_pkg::APB_DATA_W-1:0]  rdata_o,
  output logic [mc_apb_pkg::NB_RANK-1:0]     rank_mrw_o,
  output logic [mc_apb_pkg::NB_RANK-1:0]     rank_mrr_o
);

  import mc_apb_pkg::*;

  logic [RANK_IDX_W-1:0]   rank_idx_q;
  logic [NB_RANK-1:0][7:0] mr_addr_q;
  logic [NB_RANK-1:0][7:0] mr_data_q;
  logic [NB_RANK-1:0]      busy_q;
  logic [NB_RANK-1:0]      mrw_done_q;
  logic [NB_RANK-1:0]      mrr_done_q;
  logic [NB_RANK-1:0]      rank_oh;                  // all zero when index out of range
  logic [NB_RANK-1:0]      mrw_set;
  logic [NB_RANK-1:0]      mrr_set;
  logic                    ctl_we;

  always_comb
  begin
    for (int r = 0; r < NB_RANK; r++)
    begin
      rank_oh[r] = (rank_idx_q == RANK_IDX_W'(r));
    end
  end

  assign ctl_we  = wr_sel_i & byte_we_i[2];
  assign mrw_set = (ctl_we & wdata_i[MRW_BIT]) ? rank_oh : '0;
  assign mrr_set = (ctl_we & wdata_i[MRR_BIT]) ? rank_oh : '0;

  always_ff @(posedge pclk_i or negedge prst_ni)
  begin
    if (!prst_ni)
    begin
      rank_idx_q <= '0;
      mr_addr_q  <= '0;
      mr_data_q  <= '0;
      busy_q     <= '0;
      mrw_done_q <= '0;
      mrr_done_q <= '0;
      rank_mrw_o <= '0;
      rank_mrr_o <= '0;
    end
    else
    begin
      if (wr_sel_i & byte_we_i[3])
      begin
        rank_idx_q <= wdata_i[RANK_IDX_LSB +: RANK_IDX_W];
      end
      rank_mrw_o <= mrw_set;                          // one cycle wide
      rank_mrr_o <= mrr_set;
      for (int r = 0; r < NB_RANK; r++)
      begin
        if (wr_sel_i & byte_we_i[0] & rank_oh[r])
        begin
          mr_addr_q[r] <= wdata_i[7:0];
        end
        if (wr_sel_i & byte_we_i[1] & rank_oh[r])
        begin
          mr_data_q[r] <= wdata_i[15:8];
        end
        // a new command wins over a done in the same cycle
        if (mrw_set[r] | mrr_set[r])
        begin
          busy_q[r] <= 1'b1;
        end
        else if (mrw_done_i[r] | mrr_done_i[r])
        begin
          busy_q[r] <= 1'b0;
        end
        mrw_done_q[r] <= mrw_done_i[r] | (mrw_done_q[r] & ~(rd_sel_i & rank_oh[r]));
        mrr_done_q[r] <= mrr_done_i[r] | (mrr_done_q[r] & ~(rd_sel_i & rank_oh[r]));
      end
    end
  end

  // read back the indexed rank
  always_comb
  begin
    rdata_o = '0;
    if (rd_sel_i)
    begin
      rdata_o[RANK_IDX_LSB +: RANK_IDX_W] = rank_idx_q;
      for (int r = 0; r < NB_RANK; r++)
      begin
        if (rank_oh[r])
        begin
          rdata_o[7:0]          = mr_addr_q[r];
          rdata_o[15:8]         = mr_data_q[r];
          rdata_o[BUSY_BIT]     = busy_q[r];
          rdata_o[MRW_DONE_BIT] = mrw_done_q[r];
          rdata_o[MRR_DONE_BIT] = mrr_done_q[r];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/apb_reg_decode.sv
//////////////////////////////
// APB access phase decode into one-hot word selects,
// lane write enables and the unmapped-word slave error
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module apb_reg_decode (
  input  wire  [mc_apb_pkg::APB_ADDR_W-1:0] paddr_i,
  input  wire                               psel_i,
  input  wire                               penable_i,
  input  wire                               pwrite_i,
  input  wire  [3:0]                        pstrb_i,
  output logic [mc_apb_pkg::NB_WORD-1:0]    wr_sel_o,
  output logic [mc_apb_pkg::NB_WORD-1:0]    rd_sel_o,
  output logic [3:0]                        byte_we_o,
  output logic                              pready_o,
  output logic                              pslverr_o
);

  import mc_apb_pkg::*;

  logic                   access;                    // access phase cycle
  logic [WORD_ADDR_W-1:0] word_addr;
  logic [NB_WORD-1:0]     hit;

  assign access    = psel_i & penable_i;
  assign word_addr = paddr_i[APB_ADDR_W-1:2];

  //////////////////////////////
  // word match
  //////////////////////////////
  assign hit[SEL_RANK]  = (word_addr == WORD_RANK);
  assign hit[SEL_TRAIN] = (word_addr == WORD_TRAIN);
  assign hit[SEL_MRCTL] = (word_addr == WORD_MRCTL);
  assign hit[SEL_MR4]   = (word_addr == WORD_MR4);
  assign hit[SEL_ISTAT] = (word_addr == WORD_ISTAT);
  assign hit[SEL_IEN]   = (word_addr == WORD_IEN);

  //////////////////////////////
  // selects and response
  //////////////////////////////
  assign wr_sel_o  = (access & pwrite_i) ? hit : '0;
  assign rd_sel_o  = (access & ~pwrite_i) ? hit : '0;
  assign byte_we_o = (|wr_sel_o) ? pstrb_i : 4'b0000;   // lanes of a mapped write only

  assign pready_o  = psel_i;                            // zero wait states
  assign pslverr_o = access & ~(|hit);                  // unmapped word

endmodule

`default_nettype wire

//--- common/mc_apb_pkg.sv
//////////////////////////////
// word map, widths and field positions of the APB register slave
// imported by every RTL block of the controller register file
//////////////////////////////
`default_nettype none

package mc_apb_pkg;

  localparam int APB_ADDR_W  = 16;
  localparam int APB_DATA_W  = 32;
  localparam int WORD_ADDR_W = APB_ADDR_W - 2;       // paddr above the byte offset

  localparam int NB_RANK    = 2;
  localparam int RANK_IDX_W = 3;                     // index >= NB_RANK selects no rank
  localparam int ERR_W      = 7;

  localparam int MR4_TICKS_PER_UNIT = 10;
  localparam int MR4_INTERVAL_W     = 6;
  localparam int MR4_CNT_W          = 10;            // holds 63 units of 10 ticks
  localparam logic [MR4_INTERVAL_W-1:0] MR4_INTERVAL_RST = 6'd2;

  // mapped words, byte address shifted down by two
  typedef enum logic [WORD_ADDR_W-1:0] {
    WORD_RANK  = 14'h00,                             // 00h
    WORD_TRAIN = 14'h04,                             // 10h
    WORD_MRCTL = 14'h06,                             // 18h
    WORD_MR4   = 14'h10,                             // 40h
    WORD_ISTAT = 14'h18,                             // 60h
    WORD_IEN   = 14'h19                              // 64h
  } reg_word_e;

  // bit of each word in the decoder select vectors
  localparam int SEL_RANK  = 0;
  localparam int SEL_TRAIN = 1;
  localparam int SEL_MRCTL = 2;
  localparam int SEL_MR4   = 3;
  localparam int SEL_ISTAT = 4;
  localparam int SEL_IEN   = 5;
  localparam int NB_WORD   = 6;

  localparam int MRW_BIT = 16, MRR_BIT = 17, BUSY_BIT = 18, MRW_DONE_BIT = 21, MRR_DONE_BIT = 22;
  localparam int RANK_IDX_LSB = 24;
  localparam int MR4_DIS_BIT  = 11;
  localparam int ERR_LSB      = 8;                   // error fields sit in lane1

  typedef enum logic [2:0] {
    TRAIN_CA      = 3'd0,
    TRAIN_WR_DQ   = 3'd1,
    TRAIN_WR_LVL  = 3'd2,
    TRAIN_RD_LVL  = 3'd3,
    TRAIN_RD_GATE = 3'd4,
    TRAIN_ZQ      = 3'd5,
    TRAIN_ALL     = 3'd6
  } train_kind_e;

  localparam int TRAIN_W = int'(TRAIN_ALL) + 1;      // one start/busy bit per kind

endpackage

`default_nettype wire
